//--- include/rvCore_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath width, RV32
`define XLEN 32

// Architectural register count, x0 included
`define REG_COUNT 32

// Register index width, log2 of REG_COUNT
`define REG_IDX_W 5

`endif

//--- rtl/rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes, instr[6:0]
    // Only the three groups this slice executes
    typedef enum logic [6:0] {
        opOp    = 7'b0110011, // Register-register ALU
        opOpImm = 7'b0010011, // Register-immediate ALU
        opLui   = 7'b0110111  // Load upper immediate
    } opcodeT;

    // funct3, instr[14:12], for OP and OP-IMM
    typedef enum logic [2:0] {
        f3AddSub = 3'b000, // ADD/SUB, ADDI
        f3Sll    = 3'b001, // SLL, SLLI
        f3Slt    = 3'b010, // SLT, SLTI
        f3Sltu   = 3'b011, // SLTU, SLTIU
        f3Xor    = 3'b100, // XOR, XORI
        f3SrlSra = 3'b101, // SRL/SRA, bit 30 picks
        f3Or     = 3'b110, // OR, ORI
        f3And    = 3'b111  // AND, ANDI
    } funct3T;

endpackage

//--- rtl/rvCtrlPkg.sv
package rvCtrlPkg;

    // Instruction class, main decoder to ALU decoder
    typedef enum logic [2:0] {
        aluOpR   = 3'b000, // funct3 plus bit 30
        aluOpI   = 3'b001, // funct3, bit 30 only for shifts
        aluOpAdd = 3'b010  // Forced add
    } aluOpT;

    // ALU control code
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluAnd  = 4'b0010,
        aluOr   = 4'b0011,
        aluXor  = 4'b0100,
        aluSll  = 4'b0101,
        aluSrl  = 4'b0110,
        aluSra  = 4'b0111,
        aluSlt  = 4'b1000, // Signed compare
        aluSltu = 4'b1001  // Unsigned compare
    } aluCtrlT;

    // Immediate format
    typedef enum logic {
        immI = 1'b0, // instr[31:20], sign-extended
        immU = 1'b1  // instr[31:12] in the upper bits
    } immSelT;

endpackage

//--- rtl/ctrlIf.sv
interface ctrlIf;
    import rvCtrlPkg::*;

    aluCtrlT aluCtrl;  // ALU operation
    immSelT  immSel;   // I or U immediate
    logic    srcBImm;  // Operand B from immediate
    logic    srcAZero; // Operand A forced to zero, LUI
    logic    regWrite; // Write rd at the next edge
    logic    illegal;  // Unsupported opcode while valid

    // Decoder side
    modport control (output aluCtrl, immSel, srcBImm, srcAZero, regWrite, illegal);

    // Execution side
    modport datapath (input aluCtrl, immSel, srcBImm, srcAZero, regWrite, illegal);

endinterface

//--- rtl/aluDecode.sv
module aluDecode (
    input  logic               opcode5, // instr[5], OP vs OP-IMM
    input  rvIsaPkg::funct3T   funct3,  // instr[14:12]
    input  logic               funct75, // instr[30]
    input  rvCtrlPkg::aluOpT   aluOp,   // Class from main decoder
    output rvCtrlPkg::aluCtrlT aluCtrl
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic altOp;

    assign altOp = opcode5 & funct75; // Bit 30 counts only in register form

    always_comb begin
        aluCtrl = aluAdd; // Safe default
        case (aluOp)
            aluOpR: begin
                case ({funct3, altOp})
                    {f3AddSub, 1'b0}: aluCtrl = aluAdd;
                    {f3AddSub, 1'b1}: aluCtrl = aluSub;
                    {f3Xor,    1'b0}: aluCtrl = aluXor;
                    {f3Or,     1'b0}: aluCtrl = aluOr;
                    {f3And,    1'b0}: aluCtrl = aluAnd;
                    {f3Sll,    1'b0}: aluCtrl = aluSll;
                    {f3SrlSra, 1'b0}: aluCtrl = aluSrl;
                    {f3SrlSra, 1'b1}: aluCtrl = aluSra;
                    {f3Slt,    1'b0}: aluCtrl = aluSlt;
                    {f3Sltu,   1'b0}: aluCtrl = aluSltu;
                    default:          aluCtrl = aluAdd; // Undefined pairing
                endcase
            end
            aluOpI: begin
                case (funct3)
                    f3AddSub: aluCtrl = aluAdd; // No SUBI
                    f3Xor:    aluCtrl = aluXor;
                    f3Or:     aluCtrl = aluOr;
                    f3And:    aluCtrl = aluAnd;
                    f3Sll:    aluCtrl = aluSll;
                    f3SrlSra: aluCtrl = funct75 ? aluSra : aluSrl; // SRAI vs SRLI
                    f3Slt:    aluCtrl = aluSlt;
                    f3Sltu:   aluCtrl = aluSltu;
                    default:  aluCtrl = aluAdd;
                endcase
            end
            aluOpAdd: aluCtrl = aluAdd; // LUI, 0 + imm
            default:  aluCtrl = aluAdd;
        endcase
    end

    // Register ops other than ADD/SUB and shifts carry funct7 zero
    assert final (!(aluOp == aluOpR && opcode5 && funct75
                    && !(funct3 inside {f3AddSub, f3Sll, f3SrlSra})))
        else $error("aluDecode: bit 30 set on funct3 %0d", funct3);

endmodule

//--- rtl/controlUnit.sv
module controlUnit (
    input  logic [31:0] instr,
    input  logic        instrValid, // Plain strobe, no back-pressure
    ctrlIf.control      ctrl
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    opcodeT opcode;
    funct3T funct3;
    aluOpT  aluOp;
    logic   supported;

    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = funct3T'(instr[14:12]);

    // Main opcode decode
    always_comb begin
        aluOp         = aluOpAdd;
        ctrl.immSel   = immI;
        ctrl.srcBImm  = 1'b0;
        ctrl.srcAZero = 1'b0;
        supported     = 1'b1;
        case (opcode)
            opOp: begin
                aluOp = aluOpR; // rs1 op rs2
            end
            opOpImm: begin
                aluOp        = aluOpI;
                ctrl.srcBImm = 1'b1; // rs1 op imm
            end
            opLui: begin
                aluOp         = aluOpAdd;
                ctrl.immSel   = immU;
                ctrl.srcBImm  = 1'b1;
                ctrl.srcAZero = 1'b1; // 0 + U imm
            end
            default: begin
                supported = 1'b0; // Everything else is illegal here
            end
        endcase
    end

    // Both levels only mean something while valid
    assign ctrl.regWrite = instrValid & supported;
    assign ctrl.illegal  = instrValid & ~supported;

    aluDecode u_aluDecode (
        .opcode5 (instr[5]),
        .funct3  (funct3),
        .funct75 (instr[30]),
        .aluOp   (aluOp),
        .aluCtrl (ctrl.aluCtrl)
    );

endmodule

//--- rtl/immGen.sv
`include "rvCore_defs.svh"

module immGen (
    input  logic [31:0]      instr,
    ctrlIf.datapath          ctrl,
    output logic [`XLEN-1:0] imm
);
    import rvCtrlPkg::*;

    logic [`XLEN-1:0] immIType;
    logic [`XLEN-1:0] immUType;

    // 12-bit field, sign from bit 31
    assign immIType = {{(`XLEN-12){instr[31]}}, instr[31:20]};

    // Upper 20 bits, low 12 zero
    assign immUType = {instr[31:12], 12'b0};

    assign imm = (ctrl.immSel == immU) ? immUType : immIType;

endmodule

//--- rtl/regFile.sv
`include "rvCore_defs.svh"

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] rs1,
    input  logic [`REG_IDX_W-1:0] rs2,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`XLEN-1:0]      wrData,
    ctrlIf.datapath               ctrl,
    output logic [`XLEN-1:0]      rdData1,
    output logic [`XLEN-1:0]      rdData2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0; // Architectural state starts at zero
            end
        end else if (ctrl.regWrite && rd != '0) begin
            regs[rd] <= wrData; // x0 writes dropped
        end
    end

    // Asynchronous reads, x0 hard-wired
    assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

    // x0 storage never leaves zero
    assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("regFile: x0 holds %h", regs[0]);

endmodule

//--- rtl/alu.sv
`include "rvCore_defs.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    ctrlIf.datapath          ctrl,
    output logic [`XLEN-1:0] y
);
    import rvCtrlPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0]; // RV32 shift amount
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (ctrl.aluCtrl)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluXor:  y = a ^ b;
            aluSll:  y = a << shamt;
            aluSrl:  y = a >> shamt;
            aluSra:  y = $signed(a) >>> shamt; // Sign fill
            aluSlt:  y = {{(`XLEN-1){1'b0}}, ltSigned};
            aluSltu: y = {{(`XLEN-1){1'b0}}, ltUnsigned};
            default: y = '0; // Unused codes
        endcase
    end

endmodule

//--- rtl/rvExecCore.sv
`include "rvCore_defs.svh"

module rvExecCore (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           instr,
    input  logic                  instrValid,
    output logic [`XLEN-1:0]      result,   // Same-cycle ALU output
    output logic [`REG_IDX_W-1:0] rd,
    output logic                  regWrite,
    output logic                  illegal
);

    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdData1;
    logic [`XLEN-1:0] rdData2;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;

    ctrlIf ctrl ();

    assign rd = instr[11:7];

    controlUnit u_controlUnit (
        .instr      (instr),
        .instrValid (instrValid),
        .ctrl       (ctrl.control)
    );

    immGen u_immGen (
        .instr (instr),
        .ctrl  (ctrl.datapath),
        .imm   (imm)
    );

    regFile u_regFile (
        .clk     (clk),
        .reset   (reset),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .rd      (rd),
        .wrData  (result), // Writeback straight from ALU
        .ctrl    (ctrl.datapath),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    // Operand muxes
    assign opA = ctrl.srcAZero ? '0 : rdData1; // LUI
    assign opB = ctrl.srcBImm ? imm : rdData2;

    alu u_alu (
        .a    (opA),
        .b    (opB),
        .ctrl (ctrl.datapath),
        .y    (result)
    );

    assign regWrite = ctrl.regWrite;
    assign illegal  = ctrl.illegal;

endmodule

//--- tb/rvExecCoreTb.sv
`include "rvCore_defs.svh"

module rvExecCoreTb;

    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic             regWrite;
        logic             illegal;
    } expT;

    logic                  clk;
    logic                  reset;
    logic [31:0]           instr;
    logic                  instrValid;
    logic [`XLEN-1:0]      result;
    logic [`REG_IDX_W-1:0] rd;
    logic                  regWrite;
    logic                  illegal;

    logic [`XLEN-1:0] mirror [`REG_COUNT]; // Expected register contents
    logic [3:0] rOps [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    logic [3:0] iOps [9]  = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd};
    integer seed = 37;
    int checks = 0;
    int errors = 0;
    int testErrStart = 0; // Error count when the current test began
    int checkCount = 0;   // Cycles seen by the compare process

    rvExecCore u_rvExecCore (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .result     (result),
        .rd         (rd),
        .regWrite   (regWrite),
        .illegal    (illegal)
    );

    always #20 clk = ~clk; // Period 40

    function automatic logic [31:0] rTypeInstr(input logic [3:0] op, input logic [4:0] rdIdx,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, op[3], 5'b0, rs2, rs1, op[2:0], rdIdx, 7'b0110011}; // op is {bit30, funct3}
    endfunction

    function automatic logic [31:0] iTypeInstr(input logic [11:0] imm, input logic [2:0] f3,
                                               input logic [4:0] rdIdx, input logic [4:0] rs1);
        return {imm, rs1, f3, rdIdx, 7'b0010011};
    endfunction

    function automatic logic [31:0] luiInstr(input logic [19:0] imm, input logic [4:0] rdIdx);
        return {imm, rdIdx, 7'b0110111};
    endfunction

    function automatic logic [4:0] pickReg(); // Random x1..x31
        return 5'd1 + 5'($unsigned($random(seed)) % 31);
    endfunction

    // Expected outputs from the RV32I rules and the mirror
    function automatic expT refExec(input logic [31:0] i, input logic v);
        expT e;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic isR;
        logic alt;
        a = mirror[i[19:15]];
        isR = (i[6:0] == 7'b0110011);
        b = isR ? mirror[i[24:20]] : {{(`XLEN-12){i[31]}}, i[31:20]};
        alt = i[30] & (isR | i[14:12] == 3'b101); // I-type: bit 30 only on right shifts
        e.regWrite = v & (isR | i[6:0] == 7'b0010011 | i[6:0] == 7'b0110111);
        e.illegal = v & ~e.regWrite;
        case (i[14:12])
            3'b000:  e.result = alt ? a - b : a + b;
            3'b001:  e.result = a << b[4:0];
            3'b010:  e.result = ($signed(a) < $signed(b)) ? 1 : 0;
            3'b011:  e.result = (a < b) ? 1 : 0;
            3'b100:  e.result = a ^ b;
            3'b101: begin
                if (alt)
                    e.result = $signed(a) >>> b[4:0]; // Sign fill
                else
                    e.result = a >> b[4:0];
            end
            3'b110:  e.result = a | b;
            default: e.result = a & b;
        endcase
        if (isR && alt && !(i[14:12] inside {3'b000, 3'b101})) e.result = a + b; // Add fallback
        if (i[6:0] == 7'b0110111) e.result = {i[31:12], 12'b0}; // LUI
        return e;
    endfunction

    task automatic checkWord(input string name, input logic [`XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkCtrl(input logic gotWr, gotIll, expWr, expIll);
        checks++;
        if (gotWr !== expWr || gotIll !== expIll) begin
            errors++;
            $display("** Error: regWrite/illegal got %h/%h expected %h/%h",
                     gotWr, gotIll, expWr, expIll);
        end
    endtask

    task automatic checkRd(input logic [`REG_IDX_W-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: rd got %h expected %h", got, exp);
        end
    endtask

    // Compare process, outputs settled half a cycle after the driving edge
    always @(negedge clk) begin : compare
        expT e;
        if (!reset) begin
            e = refExec(instr, instrValid);
            checkCtrl(regWrite, illegal, e.regWrite, e.illegal);
            if (instrValid && !e.illegal) begin
                checkWord("result", result, e.result);
                checkRd(rd, instr[11:7]);
                if (instr[11:7] != 0) mirror[instr[11:7]] = e.result; // DUT writes at next edge
            end
            checkCount++;
        end
    end

    // One instruction per cycle, returns once the compare process has seen it
    task automatic present(input logic [31:0] word, input logic valid);
        int target;
        int waited;
        @(posedge clk);
        instr <= word;
        instrValid <= valid;
        target = checkCount + 1;
        waited = 0;
        while (checkCount < target && waited < 20) begin
            #5;
            waited++;
        end
        if (checkCount < target) begin
            $display("Timeout: instruction %h was never checked", word);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic reportTest(input string name);
        $display("%s: %s (%0d errors)", name, (errors == testErrStart) ? "ok" : "FAILED",
                 errors - testErrStart);
        testErrStart = errors;
    endtask

    initial begin
        logic [31:0] c;
        logic [31:0] rnd;
        logic [3:0]  op;
        logic [11:0] imm;
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        instrValid = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) mirror[r] = '0;
        for (int n = 0; n < 4; n++) @(posedge clk); // Reset held 4 cycles
        reset <= 1'b0;

        for (int n = 0; n < 3; n++) present($random(seed), 1'b0); // Idle, levels low
        for (int r = 1; r < 32; r++) present(rTypeInstr(4'h0, 5'd0, 5'(r), 5'(32 - r)), 1'b1);
        reportTest("reset state");

        for (int r = 1; r < 32; r++) begin
            c = $random(seed);
            present(luiInstr(c[31:12] + c[11], 5'(r)), 1'b1); // Round up for negative low part
            present(iTypeInstr(c[11:0], 3'b000, 5'(r), 5'(r)), 1'b1);
            checkWord("constant", result, c);
        end
        reportTest("lui addi constants");

        for (int k = 0; k < 50; k++) begin
            present(rTypeInstr(rOps[k % 10], pickReg(), pickReg(), pickReg()), 1'b1);
        end
        reportTest("r-type ops");

        for (int k = 0; k < 45; k++) begin
            op = iOps[k % 9];
            rnd = $random(seed);
            if (op[2:0] == 3'b001 || op[2:0] == 3'b101)
                imm = {1'b0, op[3], 5'b0, rnd[4:0]}; // Shift amount only
            else
                imm = {rnd[11] | k[0], rnd[10:0]}; // Odd passes negative
            present(iTypeInstr(imm, op[2:0], pickReg(), pickReg()), 1'b1);
        end
        reportTest("i-type ops");

        present(iTypeInstr(12'h07b, 3'b000, 5'd0, 5'd5), 1'b1); // Write to x0 dropped
        present(rTypeInstr(4'h0, 5'd7, 5'd0, 5'd0), 1'b1);
        checkWord("x0", result, '0);
        present(iTypeInstr(12'h555, 3'b000, 5'd3, 5'd0), 1'b1);
        present(rTypeInstr(4'h0, 5'd4, 5'd3, 5'd3), 1'b1); // Back-to-back dependency
        checkWord("forwarded", result, 32'haaa);
        reportTest("x0 and dependency");

        present(32'h0000_2083, 1'b1); // LW
        present(32'h0000_00ef, 1'b1); // JAL
        present(32'h0020_a023, 1'b1); // SW
        present(32'h0000_0097, 1'b1); // AUIPC
        rnd = $random(seed);
        present({rnd[31:7], 7'b1110011}, 1'b1); // SYSTEM
        for (int r = 1; r < 32; r++) present(rTypeInstr(4'h0, 5'd0, 5'(r), 5'd0), 1'b1);
        present('0, 1'b0);
        reportTest("illegal opcodes");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
rtl/rvIsaPkg.sv
rtl/rvCtrlPkg.sv
rtl/ctrlIf.sv
rtl/aluDecode.sv
rtl/controlUnit.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/alu.sv
rtl/rvExecCore.sv
tb/rvExecCoreTb.sv

//--- Bender.yml
package:
  name: rv_exec_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/rvIsaPkg.sv
      - rtl/rvCtrlPkg.sv
      - rtl/ctrlIf.sv
      - rtl/aluDecode.sv
      - rtl/controlUnit.sv
      - rtl/immGen.sv
      - rtl/regFile.sv
      - rtl/alu.sv
      - rtl/rvExecCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/rvExecCoreTb.sv
